//--- source/cpuSm_defines.svh
// CPU bus master constants
`ifndef CPU_SM_DEFINES_SVH
`define CPU_SM_DEFINES_SVH

`define CPU_SM_STATE_W 5
`define CPU_SM_TERM_W 16          // indices above T_STOP read zero

`define T_START_WR    0           // full FIFO, write to memory
`define T_START_RD    1           // FIFO has room, read from memory
`define T_START_FLUSH 2           // drain a partial FIFO
`define T_GRANTED     3
`define T_GRANT_WAIT  4
`define T_STROBE      5
`define T_ACKED       6
`define T_ACK_WAIT    7
`define T_CONT_WR     8
`define T_CONT_RD     9
`define T_FLUSH_END   10
`define T_STOP        11

`endif

//--- source/cpuSmPkg.sv
// CPU bus master types
`include "cpuSm_defines.svh"

package cpuSmPkg;

  // encodings kept from the original state assignment
  typedef enum logic [`CPU_SM_STATE_W-1:0] {
    sIdle      = 5'd0,
    sAddr      = 5'd1,
    sBusReq    = 5'd2,
    sDataWait  = 5'd3,
    sAck       = 5'd28,
    sFlushDone = 5'd30
  } cpuSmState_t;

endpackage

//--- source/cpuSmInputs.sv
// CPU bus master input terms
`include "cpuSm_defines.svh"

module cpuSmInputs import cpuSmPkg::*; (
  input  logic                      CLK90,
  input  logic                      RST_,
  input  logic                      A1,
  input  logic                      BGRANT_,
  input  logic                      BOEQ3,
  input  logic                      CYCLEDONE,
  input  logic                      DMADIR,
  input  logic                      DMAENA,
  input  logic                      DREQ_,
  input  logic                      DSACK0_,
  input  logic                      DSACK1_,
  input  logic                      FIFOEMPTY,
  input  logic                      FIFOFULL,
  input  logic                      FLUSHFIFO,
  input  logic                      LASTWORD,
  input  cpuSmState_t               STATE,
  output logic [`CPU_SM_TERM_W-1:0] E
);

  logic dsack0Ack;                  // synchronised, active high
  logic dsack1Ack;
  logic bothAck;                    // full 32-bit acknowledge
  logic inIdle;
  logic inBusReq;
  logic inAddr;
  logic inDataWait;
  logic inAck;
  logic contWr;
  logic contRd;
  logic flushEnd;

  always_ff @(posedge CLK90 or negedge RST_) begin
    if (!RST_) begin
      dsack0Ack <= 1'b0;
      dsack1Ack <= 1'b0;
    end else begin
      dsack0Ack <= ~DSACK0_;
      dsack1Ack <= ~DSACK1_;
    end
  end

  assign bothAck    = dsack0Ack & dsack1Ack;

  assign inIdle     = STATE == sIdle;
  assign inBusReq   = STATE == sBusReq;
  assign inAddr     = STATE == sAddr;
  assign inDataWait = STATE == sDataWait;
  assign inAck      = STATE == sAck;

  // sAck exits, shared with the stop term
  assign contWr   = inAck & DMAENA & DMADIR & ~FIFOEMPTY;
  assign contRd   = inAck & DMAENA & ~DMADIR & ~FIFOFULL;
  assign flushEnd = inAck & DMADIR & FIFOEMPTY & LASTWORD & BOEQ3;

  // product terms, one per transition
  always_comb begin
    E                 = '0;
    E[`T_START_WR]    = inIdle & DMAENA & DMADIR & FIFOFULL;
    E[`T_START_RD]    = inIdle & DMAENA & ~DMADIR & ~FIFOFULL;
    E[`T_START_FLUSH] = inIdle & DMAENA & DMADIR & FLUSHFIFO & ~FIFOEMPTY;
    E[`T_GRANTED]     = inBusReq & ~BGRANT_ & CYCLEDONE;
    E[`T_GRANT_WAIT]  = inBusReq & (BGRANT_ | ~CYCLEDONE);
    E[`T_STROBE]      = inAddr;
    E[`T_ACKED]       = inDataWait & bothAck;
    E[`T_ACK_WAIT]    = inDataWait & ~bothAck;
    E[`T_CONT_WR]     = contWr;
    E[`T_CONT_RD]     = contRd;
    E[`T_FLUSH_END]   = flushEnd;
    E[`T_STOP]        = inAck & ~(contWr | contRd | flushEnd);
  end

  // an ack term needs both strobes low one edge earlier
  assert property (@(posedge CLK90) disable iff (!RST_)
    E[`T_ACKED] |-> $past(!DSACK0_ && !DSACK1_));

  // byte lane and request lines settle once the bus master is active
  assert property (@(posedge CLK90) disable iff (!RST_)
    !inIdle |-> !$isunknown({A1, BOEQ3, DREQ_}));

endmodule

//--- source/cpuSmNextState.sv
// CPU bus master state register
`include "cpuSm_defines.svh"

module cpuSmNextState import cpuSmPkg::*; (
  input  logic                      CLK90,
  input  logic                      RST_,
  input  logic [`CPU_SM_TERM_W-1:0] E,
  output cpuSmState_t               STATE,
  output cpuSmState_t               nextState
);

  logic anyStart;
  logic anyCont;

  assign anyStart = E[`T_START_WR] | E[`T_START_RD] | E[`T_START_FLUSH];
  assign anyCont  = E[`T_CONT_WR] | E[`T_CONT_RD];

  // first true term wins
  always_comb begin
    nextState = STATE;                  // no term, hold
    if (anyStart) begin
      nextState = sBusReq;
    end else if (E[`T_GRANTED]) begin
      nextState = sAddr;
    end else if (E[`T_GRANT_WAIT]) begin
      nextState = sBusReq;              // grant withheld
    end else if (E[`T_STROBE]) begin
      nextState = sDataWait;
    end else if (E[`T_ACKED]) begin
      nextState = sAck;
    end else if (E[`T_ACK_WAIT]) begin
      nextState = sDataWait;            // slave not ready
    end else if (anyCont) begin
      nextState = sAddr;                // keep the bus, next word
    end else if (E[`T_FLUSH_END]) begin
      nextState = sFlushDone;
    end else if (E[`T_STOP]) begin
      nextState = sIdle;
    end else if (STATE == sFlushDone) begin
      nextState = sIdle;                // done pulse lasts one cycle
    end
  end

  always_ff @(posedge CLK90 or negedge RST_) begin
    if (!RST_) begin
      STATE <= sIdle;
    end else begin
      STATE <= nextState;
    end
  end

  assert property (@(posedge CLK90) disable iff (!RST_)
    STATE inside {sIdle, sBusReq, sAddr, sDataWait, sAck, sFlushDone});

  // sAck exits decoded in the input stage must not overlap or leave a gap
  assert property (@(posedge CLK90) disable iff (!RST_)
    (STATE == sAck) |->
      $onehot({E[`T_CONT_WR], E[`T_CONT_RD], E[`T_FLUSH_END], E[`T_STOP]}));

endmodule

//--- source/cpuSmOutputs.sv
// CPU bus master output strobes
module cpuSmOutputs import cpuSmPkg::*; (
  input  logic        CLK90,
  input  logic        RST_,
  input  cpuSmState_t nextState,
  input  logic        DMADIR,
  output logic        BR_,
  output logic        BGACK_,
  output logic        AS_,
  output logic        DS_,
  output logic        fifoPop,
  output logic        fifoPush,
  output logic        flushDone
);

  logic busOwned;                       // we hold the bus next cycle
  logic strobeOn;                       // address and data strobes
  logic wordDone;

  assign busOwned = nextState inside {sAddr, sDataWait, sAck};
  assign strobeOn = nextState inside {sAddr, sDataWait};
  assign wordDone = nextState == sAck;

  // decoded from nextState so each strobe lines up with its state
  always_ff @(posedge CLK90 or negedge RST_) begin
    if (!RST_) begin
      BR_       <= 1'b1;
      BGACK_    <= 1'b1;
      AS_       <= 1'b1;
      DS_       <= 1'b1;
      fifoPop   <= 1'b0;
      fifoPush  <= 1'b0;
      flushDone <= 1'b0;
    end else begin
      BR_       <= nextState != sBusReq;
      BGACK_    <= ~busOwned;
      AS_       <= ~strobeOn;
      DS_       <= ~strobeOn;
      fifoPop   <= wordDone & DMADIR;   // FIFO to memory
      fifoPush  <= wordDone & ~DMADIR;  // memory to FIFO
      flushDone <= nextState == sFlushDone;
    end
  end

  // never drive an address without owning the bus
  assert property (@(posedge CLK90) disable iff (!RST_)
    !AS_ |-> !BGACK_);

endmodule

//--- source/cpuSm.sv
// CPU bus master top level
`include "cpuSm_defines.svh"

module cpuSm import cpuSmPkg::*; (
  input  logic CLK90,
  input  logic RST_,
  input  logic A1,
  input  logic BGRANT_,
  input  logic BOEQ3,
  input  logic CYCLEDONE,
  input  logic DMADIR,
  input  logic DMAENA,
  input  logic DREQ_,                   // SCSI side request, observed only
  input  logic DSACK0_,
  input  logic DSACK1_,
  input  logic FIFOEMPTY,
  input  logic FIFOFULL,
  input  logic FLUSHFIFO,
  input  logic LASTWORD,
  output logic BR_,
  output logic BGACK_,
  output logic AS_,
  output logic DS_,
  output logic fifoPop,
  output logic fifoPush,
  output logic flushDone
);

  logic [`CPU_SM_TERM_W-1:0] terms;
  cpuSmState_t               state;
  cpuSmState_t               nextState;

  cpuSmInputs inputs_i (
    .CLK90     (CLK90),
    .RST_      (RST_),
    .A1        (A1),
    .BGRANT_   (BGRANT_),
    .BOEQ3     (BOEQ3),
    .CYCLEDONE (CYCLEDONE),
    .DMADIR    (DMADIR),
    .DMAENA    (DMAENA),
    .DREQ_     (DREQ_),
    .DSACK0_   (DSACK0_),
    .DSACK1_   (DSACK1_),
    .FIFOEMPTY (FIFOEMPTY),
    .FIFOFULL  (FIFOFULL),
    .FLUSHFIFO (FLUSHFIFO),
    .LASTWORD  (LASTWORD),
    .STATE     (state),
    .E         (terms)
  );

  cpuSmNextState nextState_i (
    .CLK90     (CLK90),
    .RST_      (RST_),
    .E         (terms),
    .STATE     (state),
    .nextState (nextState)
  );

  cpuSmOutputs outputs_i (
    .CLK90     (CLK90),
    .RST_      (RST_),
    .nextState (nextState),
    .DMADIR    (DMADIR),
    .BR_       (BR_),
    .BGACK_    (BGACK_),
    .AS_       (AS_),
    .DS_       (DS_),
    .fifoPop   (fifoPop),
    .fifoPush  (fifoPush),
    .flushDone (flushDone)
  );

endmodule

//--- testbench/cpuSmTb.sv
// CPU bus master testbench
module cpuSmTb;

  localparam int DEPTH     = 8;
  localparam int NUM_CASES = 8;

  typedef struct {
    logic dir;
    int   startCount;
    logic flush;
    logic lastWord;
    logic boeq3;
    int   grantDelay;
    int   ackDelay;
    int   expPop;
    int   expPush;
    int   expDone;
  } caseRow_t;

  logic CLK90     = 1'b0;
  logic RST_      = 1'b0;
  logic A1        = 1'b0;
  logic BGRANT_   = 1'b1;
  logic BOEQ3     = 1'b0;
  logic CYCLEDONE = 1'b1;             // previous owner always off the bus
  logic DMADIR    = 1'b0;
  logic DMAENA    = 1'b0;
  logic DREQ_     = 1'b1;
  logic DSACK0_   = 1'b1;
  logic DSACK1_   = 1'b1;
  logic FLUSHFIFO = 1'b0;
  logic LASTWORD  = 1'b0;
  logic FIFOEMPTY;
  logic FIFOFULL;
  logic BR_, BGACK_, AS_, DS_;
  logic fifoPop, fifoPush, flushDone;

  caseRow_t rows[NUM_CASES];
  int   rowCount   = 0;
  int   errorCount = 0;
  int   grantDelay = 0;
  int   ackDelay   = 0;
  int   grantCnt   = 0;
  int   ackCnt     = 0;
  int   fifoCount  = 0;
  int   fifoLevel;
  int   loadCount  = 0;
  logic loadReq    = 1'b0;
  int   popTotal   = 0;
  int   pushTotal  = 0;
  int   doneTotal  = 0;
  logic ackedLast  = 1'b0;            // previous cycle was acknowledged

  cpuSm dut_i (
    .CLK90     (CLK90),
    .RST_      (RST_),
    .A1        (A1),
    .BGRANT_   (BGRANT_),
    .BOEQ3     (BOEQ3),
    .CYCLEDONE (CYCLEDONE),
    .DMADIR    (DMADIR),
    .DMAENA    (DMAENA),
    .DREQ_     (DREQ_),
    .DSACK0_   (DSACK0_),
    .DSACK1_   (DSACK1_),
    .FIFOEMPTY (FIFOEMPTY),
    .FIFOFULL  (FIFOFULL),
    .FLUSHFIFO (FLUSHFIFO),
    .LASTWORD  (LASTWORD),
    .BR_       (BR_),
    .BGACK_    (BGACK_),
    .AS_       (AS_),
    .DS_       (DS_),
    .fifoPop   (fifoPop),
    .fifoPush  (fifoPush),
    .flushDone (flushDone)
  );

  always #20 CLK90 = ~CLK90;

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  // arbiter, grants after BR_ low plus a delay
  always @(posedge CLK90) begin
    if (!BR_) begin
      if (grantCnt >= grantDelay) begin
        BGRANT_ <= 1'b0;
      end else begin
        grantCnt <= grantCnt + 1;
      end
    end else if (BGACK_) begin
      BGRANT_  <= 1'b1;               // bus released
      grantCnt <= 0;
    end
  end

  // memory slave, full 32-bit acknowledge
  always @(posedge CLK90) begin
    if (!AS_ && !DS_) begin
      if (ackCnt >= ackDelay) begin
        DSACK0_ <= 1'b0;
        DSACK1_ <= 1'b0;
      end else begin
        ackCnt <= ackCnt + 1;
      end
    end else begin
      DSACK0_ <= 1'b1;
      DSACK1_ <= 1'b1;
      ackCnt  <= 0;
    end
  end

  // FIFO model, flags count the word in flight
  assign fifoLevel = fifoCount - int'(fifoPop) + int'(fifoPush);
  assign FIFOEMPTY = fifoLevel == 0;
  assign FIFOFULL  = fifoLevel == DEPTH;

  always @(posedge CLK90) begin
    if (loadReq) begin
      fifoCount <= loadCount;
    end else begin
      fifoCount <= fifoLevel;
    end
  end

  // bus protocol and strobe counting
  always @(posedge CLK90) begin
    if (RST_) begin
      if (!AS_) begin
        checkValue("BGACK_ while AS_ low", 32'(BGACK_), 0);
      end
      if (fifoPop || fifoPush) begin
        checkValue("AS_ at FIFO strobe", 32'(AS_), 1);
        checkValue("DS_ at FIFO strobe", 32'(DS_), 1);
        checkValue("BGACK_ at FIFO strobe", 32'(BGACK_), 0);
        checkValue("acknowledge before FIFO strobe", 32'(ackedLast), 1);
      end
      popTotal  <= popTotal + int'(fifoPop);
      pushTotal <= pushTotal + int'(fifoPush);
      doneTotal <= doneTotal + int'(flushDone);
      ackedLast <= !AS_ && !DSACK0_ && !DSACK1_;
    end
  end

  task automatic addRow(input logic dir, input int startCount, input logic flush,
                        input logic lastWord, input logic boeq3, input int expPop,
                        input int expPush, input int expDone);
    caseRow_t row;
    row.dir        = dir;
    row.startCount = startCount;
    row.flush      = flush;
    row.lastWord   = lastWord;
    row.boeq3      = boeq3;
    row.grantDelay = $urandom % 5;
    row.ackDelay   = $urandom % 5;
    row.expPop     = expPop;
    row.expPush    = expPush;
    row.expDone    = expDone;
    rows[rowCount] = row;
    rowCount++;
  endtask

  task automatic idleAfterReset();
    repeat (20) begin
      @(posedge CLK90);
      checkValue("{BR_,BGACK_,AS_,DS_} idle", 32'({BR_, BGACK_, AS_, DS_}), 32'hf);
    end
    checkValue("strobes while disabled", popTotal + pushTotal + doneTotal, 0);
  endtask

  task automatic runRow(input int idx);
    caseRow_t row;
    int       popStart;
    int       pushStart;
    int       doneStart;
    row = rows[idx];
    @(posedge CLK90);
    DMADIR     <= row.dir;
    FLUSHFIFO  <= row.flush;
    LASTWORD   <= row.lastWord;
    BOEQ3      <= row.boeq3;
    grantDelay <= row.grantDelay;
    ackDelay   <= row.ackDelay;
    loadCount  <= row.startCount;
    loadReq    <= 1'b1;
    @(posedge CLK90);
    loadReq   <= 1'b0;
    DMAENA    <= 1'b1;
    popStart  = popTotal;
    pushStart = pushTotal;
    doneStart = doneTotal;
    while (BGACK_ !== 1'b0) @(posedge CLK90);   // bus taken
    while (BGACK_ !== 1'b1) @(posedge CLK90);   // bus released
    repeat (3) @(posedge CLK90);
    DMAENA <= 1'b0;
    repeat (2) @(posedge CLK90);
    checkValue($sformatf("row %0d fifoPop count", idx), popTotal - popStart, row.expPop);
    checkValue($sformatf("row %0d fifoPush count", idx), pushTotal - pushStart, row.expPush);
    checkValue($sformatf("row %0d flushDone count", idx), doneTotal - doneStart, row.expDone);
    checkValue($sformatf("row %0d final FIFO count", idx), fifoCount, row.dir ? 0 : DEPTH);
    checkValue($sformatf("row %0d BGACK_ at end", idx), 32'(BGACK_), 1);
    checkValue($sformatf("row %0d BR_ at end", idx), 32'(BR_), 1);
  endtask

  initial begin
    void'($urandom(32'h122e));
    //     dir   count flush lastw boeq3 pop push done
    addRow(1'b1, 8,    1'b0, 1'b0, 1'b0, 8,  0,   0);  // full FIFO to memory
    addRow(1'b0, 0,    1'b0, 1'b0, 1'b0, 0,  8,   0);  // fill an empty FIFO
    addRow(1'b0, 5,    1'b0, 1'b0, 1'b0, 0,  3,   0);
    addRow(1'b1, 3,    1'b1, 1'b1, 1'b1, 3,  0,   1);  // flush with done pulse
    addRow(1'b1, 3,    1'b1, 1'b1, 1'b0, 3,  0,   0);  // offset not 3, no done
    addRow(1'b1, 8,    1'b0, 1'b0, 1'b0, 8,  0,   0);
    addRow(1'b1, 1,    1'b1, 1'b1, 1'b1, 1,  0,   1);  // single word flush
    addRow(1'b0, 7,    1'b0, 1'b0, 1'b0, 0,  1,   0);
    repeat (10) @(posedge CLK90);
    RST_ <= 1'b1;
    idleAfterReset();
    for (int idx = 0; idx < rowCount; idx++) begin
      runRow(idx);
    end
    $display("Errors: %0d", errorCount);
    if (errorCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (NUM_CASES * 400) @(posedge CLK90);
    $display("Timeout: the bus master did not finish all cases in %0d cycles", NUM_CASES * 400);
    $display("Errors: %0d", errorCount);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- src.f
+incdir+source
source/cpuSmPkg.sv
source/cpuSmInputs.sv
source/cpuSmNextState.sv
source/cpuSmOutputs.sv
source/cpuSm.sv
testbench/cpuSmTb.sv

//--- Makefile
TOP := cpuSmTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
